// File: intc_priority_top.f
rtl/intc_pkg.sv
rtl/ipr_bank.sv
rtl/ipr_group_max.sv
rtl/level_merge_tree.sv
rtl/intc_priority_top.sv
verification/intc_priority_checker.sv
verification/intc_priority_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
set -u
cd "$(dirname "$0")" || exit 1

top=intc_priority_tb
obj_dir=obj_dir
build_log=build.log
sim_log=sim.log

rm -f "$sim_log"

verilator --binary --timing --assert -j 0 \
  --top-module "$top" --Mdir "$obj_dir" -o "$top" \
  -f intc_priority_top.f > "$build_log" 2>&1 \
  || { echo "Build failed, see $build_log"; exit 1; }

"./$obj_dir/$top" > "$sim_log" 2>&1 \
  || echo "Simulation returned a nonzero status"

grep -qx "all tests passed" "$sim_log" \
  && { echo "Result: PASS"; exit 0; } \
  || { echo "Result: FAIL, see $sim_log"; exit 1; }

// File: verification/intc_priority_tb.sv
`timescale 1ns/10ps

module intc_priority_tb;

  localparam int unsigned SEED = 32'hf12d_9d69;
  localparam int HS_TIMEOUT    = 10;
  localparam int RESET_CYCLES  = 5;

  // Worst case for one write: both ack waits run to their limit
  localparam int WRITE_CYCLES   = 2 * HS_TIMEOUT + 2;
  localparam int NUM_WRITES     = 18;
  // Drive edge plus the two register stages
  localparam int REQUEST_CYCLES = 3;
  localparam int NUM_REQUESTS   = 10;
  localparam int RANDOM_CYCLES  = 200;
  localparam int TOTAL_CYCLES   = RESET_CYCLES + 1
                                + NUM_WRITES * WRITE_CYCLES
                                + NUM_REQUESTS * REQUEST_CYCLES
                                + RANDOM_CYCLES + 3;
  localparam int WATCHDOG_NS    = TOTAL_CYCLES * 10 + 1000;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               wr_req;
  intc_pkg::ipr_wr_t  wr;
  intc_pkg::src_req_t src_req;
  logic               wr_ack;
  intc_pkg::level_t   max_priority;

  // Register words as the writer sent them
  logic [intc_pkg::IPR_W-1:0] model_ipr [intc_pkg::NUM_IPR];

  intc_priority_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_req       (wr_req),
    .wr           (wr),
    .src_req      (src_req),
    .wr_ack       (wr_ack),
    .max_priority (max_priority)
  );

  bind intc_priority_top intc_priority_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_req       (wr_req),
    .wr_ack       (wr_ack),
    .src_req      (src_req),
    .max_priority (max_priority)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t",
                          name, actual, expected, $time));
    end
  endtask

  // Highest level among requesting sources, 0 if none
  function automatic intc_pkg::level_t expected_max(input intc_pkg::src_req_t req);
    logic [intc_pkg::IPR_W-1:0] word;
    intc_pkg::level_t           lvl;
    intc_pkg::level_t           best;
    int                         lsb;
    best = '0;
    for (int s = 0; s < intc_pkg::NUM_SRC; s++) begin
      if (req[s]) begin
        word = model_ipr[s / intc_pkg::FIELDS_PER_IPR];
        // Field 0 sits in bits 14:12, field 3 in bits 2:0
        lsb  = 12 - 4 * (s % intc_pkg::FIELDS_PER_IPR);
        lvl  = word[lsb +: intc_pkg::LEVEL_W];
        if (lvl > best) begin
          best = lvl;
        end
      end
    end
    return best;
  endfunction

  task automatic write_ipr(input logic [intc_pkg::IPR_ADDR_W-1:0] addr,
                           input logic [intc_pkg::IPR_W-1:0] data);
    int waited;
    @(negedge clk);
    wr.addr = addr;
    wr.data = data;
    wr_req  = 1'b1;
    waited  = 0;
    while (!wr_ack) begin
      if (waited == HS_TIMEOUT) begin
        abort_run($sformatf("wr_ack did not rise within %0d cycles for a write to address %0d",
                            HS_TIMEOUT, addr));
      end
      @(negedge clk);
      waited++;
    end
    wr_req = 1'b0;
    waited = 0;
    while (wr_ack) begin
      if (waited == HS_TIMEOUT) begin
        abort_run($sformatf("wr_ack did not fall within %0d cycles after wr_req dropped",
                            HS_TIMEOUT));
      end
      @(negedge clk);
      waited++;
    end
    // Addresses 14 and 15 are acknowledged but hold nothing
    if (int'(addr) < intc_pkg::NUM_IPR) begin
      model_ipr[addr] = data;
    end
  endtask

  task automatic apply_request(input intc_pkg::src_req_t req);
    intc_pkg::level_t expected;
    expected = expected_max(req);
    @(negedge clk);
    src_req = req;
    repeat (2) @(negedge clk);
    compare_value("max_priority", 32'(max_priority), 32'(expected));
  endtask

  task automatic reset_state_test();
    compare_value("wr_ack", 32'(wr_ack), 32'h0);
    apply_request('1);
  endtask

  task automatic single_source_test();
    intc_pkg::src_req_t req;
    // IPRA levels 3, 6, 1, 5 with every spare bit set
    write_ipr(4'd0, 16'hbe9d);
    for (int s = 0; s < intc_pkg::FIELDS_PER_IPR; s++) begin
      req    = '0;
      req[s] = 1'b1;
      apply_request(req);
    end
  endtask

  task automatic masking_test();
    intc_pkg::src_req_t req;
    // IPRB levels 6, 2, 5, 1
    write_ipr(4'd1, 16'h6251);
    req    = '0;
    req[5] = 1'b1;
    apply_request(req);
    req[7] = 1'b1;
    apply_request(req);
    apply_request('0);
  endtask

  task automatic bad_address_test();
    intc_pkg::src_req_t req;
    write_ipr(4'd14, 16'h7777);
    write_ipr(4'd15, 16'h7777);
    apply_request('1);
    req                       = '0;
    req[intc_pkg::NUM_SRC-1] = 1'b1;
    apply_request(req);
  endtask

  task automatic random_traffic_test();
    logic [31:0]        rand_word;
    logic [63:0]        rand_bits;
    intc_pkg::src_req_t vec;
    intc_pkg::level_t   expected;
    intc_pkg::level_t   expected_q [$];
    for (int k = 0; k < intc_pkg::NUM_IPR; k++) begin
      rand_word = $urandom();
      write_ipr(4'(k), rand_word[intc_pkg::IPR_W-1:0]);
    end
    // New vector every cycle, results trail by two cycles
    for (int i = 0; i < RANDOM_CYCLES + 2; i++) begin
      @(negedge clk);
      if (i >= 2) begin
        expected = expected_q.pop_front();
        compare_value("max_priority", 32'(max_priority), 32'(expected));
      end
      if (i < RANDOM_CYCLES) begin
        rand_bits = {$urandom(), $urandom()};
        vec       = rand_bits[intc_pkg::NUM_SRC-1:0];
        src_req   = vec;
        expected_q.push_back(expected_max(vec));
      end
    end
    src_req = '0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("Watchdog expired after %0d ns before the tests finished",
                        WATCHDOG_NS));
  end

  initial begin
    int unsigned seed_state;
    seed_state = $urandom(SEED);
    rst_n      = 1'b0;
    wr_req     = 1'b0;
    wr         = '0;
    src_req    = '0;
    for (int k = 0; k < intc_pkg::NUM_IPR; k++) begin
      model_ipr[k] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    single_source_test();
    masking_test();
    bad_address_test();
    random_traffic_test();

    $display("all tests passed");
    $finish;
  end

endmodule : intc_priority_tb

// File: verification/intc_priority_checker.sv
`timescale 1ns/10ps

module intc_priority_checker (
  input logic               clk,
  input logic               rst_n,
  input logic               wr_req,
  input logic               wr_ack,
  input intc_pkg::src_req_t src_req,
  input intc_pkg::level_t   max_priority
);

  // Ack only rises in answer to a request
  a_ack_rise: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(wr_ack) |-> $past(wr_req)
  ) else $error("wr_ack rose while wr_req was low");

  // Ack only drops once the request is gone
  a_ack_fall: assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(wr_ack) |-> !$past(wr_req)
  ) else $error("wr_ack fell while wr_req was still high");

  a_ack_reset: assert property (
    @(posedge clk)
    !rst_n |=> !wr_ack
  ) else $error("wr_ack high in the cycle after reset");

  // Two register stages from request to result
  a_idle_result: assert property (
    @(posedge clk) disable iff (!rst_n)
    ($past(src_req, 2) == '0) |-> (max_priority == '0)
  ) else $error("max_priority nonzero two cycles after an all-zero src_req");

endmodule : intc_priority_checker

// File: rtl/intc_priority_top.sv
`timescale 1ns/10ps

module intc_priority_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr_req,
  input  intc_pkg::ipr_wr_t  wr,
  input  intc_pkg::src_req_t src_req,
  output logic               wr_ack,
  output intc_pkg::level_t   max_priority
);

  intc_pkg::ipr_t   ipr       [intc_pkg::NUM_IPR];
  intc_pkg::level_t group_max [intc_pkg::NUM_IPR];

  ipr_bank u_bank (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .wr     (wr),
    .wr_ack (wr_ack),
    .ipr    (ipr)
  );

  // One unit per IPR, four request bits each
  for (genvar k = 0; k < intc_pkg::NUM_IPR; k++) begin : g_group
    ipr_group_max u_group (
      .clk       (clk),
      .rst_n     (rst_n),
      .ipr       (ipr[k]),
      .req       (src_req[k*intc_pkg::FIELDS_PER_IPR +: intc_pkg::FIELDS_PER_IPR]),
      .group_max (group_max[k])
    );
  end

  level_merge_tree u_tree (
    .clk          (clk),
    .rst_n        (rst_n),
    .group_max    (group_max),
    .max_priority (max_priority)
  );

endmodule : intc_priority_top

// File: rtl/level_merge_tree.sv
`timescale 1ns/10ps

module level_merge_tree (
  input  logic             clk,
  input  logic             rst_n,
  input  intc_pkg::level_t group_max [intc_pkg::NUM_IPR],
  output intc_pkg::level_t max_priority
);

  intc_pkg::level_t pair_max [intc_pkg::NUM_IPR/2];
  intc_pkg::level_t max_abcd;
  intc_pkg::level_t max_efgh;
  intc_pkg::level_t max_ijkl;
  intc_pkg::level_t max_mn;
  intc_pkg::level_t max_abcdefgh;
  intc_pkg::level_t max_ijkl_mn;
  intc_pkg::level_t max_final;

  // AB, CD, EF, GH, IJ, KL, MN
  for (genvar p = 0; p < intc_pkg::NUM_IPR/2; p++) begin : g_pair
    assign pair_max[p] = intc_pkg::max_level(group_max[2*p], group_max[2*p+1]);
  end

  // Groups of four registers
  assign max_abcd = intc_pkg::max_level(pair_max[0], pair_max[1]);
  assign max_efgh = intc_pkg::max_level(pair_max[2], pair_max[3]);
  assign max_ijkl = intc_pkg::max_level(pair_max[4], pair_max[5]);

  // MN has no partner at this level
  assign max_mn = pair_max[6];

  // Halves
  assign max_abcdefgh = intc_pkg::max_level(max_abcd, max_efgh);
  assign max_ijkl_mn  = intc_pkg::max_level(max_ijkl, max_mn);

  assign max_final = intc_pkg::max_level(max_abcdefgh, max_ijkl_mn);

  // Second pipeline stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      max_priority <= '0;
    end else begin
      max_priority <= max_final;
    end
  end

endmodule : level_merge_tree

// File: rtl/ipr_group_max.sv
`timescale 1ns/10ps

module ipr_group_max (
  input  logic                                clk,
  input  logic                                rst_n,
  input  intc_pkg::ipr_t                      ipr,
  input  logic [intc_pkg::FIELDS_PER_IPR-1:0] req,
  output intc_pkg::level_t                    group_max
);

  intc_pkg::level_t sel_14_12;
  intc_pkg::level_t sel_10_8;
  intc_pkg::level_t sel_6_4;
  intc_pkg::level_t sel_2_0;
  intc_pkg::level_t max_hi;
  intc_pkg::level_t max_lo;
  intc_pkg::level_t max_all;

  // A silent source counts as level 0
  always_comb begin
    sel_14_12 = req[0] ? ipr.pri_14_12 : '0;
    sel_10_8  = req[1] ? ipr.pri_10_8  : '0;
    sel_6_4   = req[2] ? ipr.pri_6_4   : '0;
    sel_2_0   = req[3] ? ipr.pri_2_0   : '0;
  end

  // Two pairs, then the pair of results
  assign max_hi  = intc_pkg::max_level(sel_14_12, sel_10_8);
  assign max_lo  = intc_pkg::max_level(sel_6_4, sel_2_0);
  assign max_all = intc_pkg::max_level(max_hi, max_lo);

  // First pipeline stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      group_max <= '0;
    end else begin
      group_max <= max_all;
    end
  end

endmodule : ipr_group_max

// File: rtl/ipr_bank.sv
`timescale 1ns/10ps

module ipr_bank (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_req,
  input  intc_pkg::ipr_wr_t wr,
  output logic             wr_ack,
  output intc_pkg::ipr_t   ipr [intc_pkg::NUM_IPR]
);

  logic                        wr_start;
  logic [intc_pkg::NUM_IPR-1:0] wr_sel;
  intc_pkg::ipr_t              wr_data;

  // New transaction: request seen while ack still low
  assign wr_start = wr_req & ~wr_ack;

  // Address decode, 14 and 15 select nothing
  always_comb begin
    wr_sel = '0;
    for (int k = 0; k < intc_pkg::NUM_IPR; k++) begin
      if (wr.addr == k[intc_pkg::IPR_ADDR_W-1:0]) begin
        wr_sel[k] = wr_start;
      end
    end
  end

  // Spare bits are never stored
  always_comb begin
    wr_data         = wr.data;
    wr_data.rsvd_15 = 1'b0;
    wr_data.rsvd_11 = 1'b0;
    wr_data.rsvd_7  = 1'b0;
    wr_data.rsvd_3  = 1'b0;
  end

  // Four-phase ack
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ack <= 1'b0;
    end else if (wr_start) begin
      wr_ack <= 1'b1;
    end else if (!wr_req) begin
      wr_ack <= 1'b0;
    end
  end

  // Priority registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < intc_pkg::NUM_IPR; k++) begin
        ipr[k] <= '0;
      end
    end else begin
      for (int k = 0; k < intc_pkg::NUM_IPR; k++) begin
        if (wr_sel[k]) begin
          ipr[k] <= wr_data;
        end
      end
    end
  end

endmodule : ipr_bank

// File: rtl/intc_pkg.sv
package intc_pkg;

  // Sizes of the priority register file
  localparam int LEVEL_W        = 3;
  localparam int FIELDS_PER_IPR = 4;
  localparam int NUM_IPR        = 14;
  localparam int NUM_SRC        = NUM_IPR * FIELDS_PER_IPR;
  localparam int IPR_W          = 16;
  localparam int IPR_ADDR_W     = 4;

  // Level 0 means no interrupt
  typedef logic [LEVEL_W-1:0] level_t;

  // One IPR, four fields with a spare bit above each
  typedef struct packed {
    logic   rsvd_15;
    level_t pri_14_12;
    logic   rsvd_11;
    level_t pri_10_8;
    logic   rsvd_7;
    level_t pri_6_4;
    logic   rsvd_3;
    level_t pri_2_0;
  } ipr_t;

  // Register write carried by the req/ack port
  typedef struct packed {
    logic [IPR_ADDR_W-1:0] addr;
    ipr_t                  data;
  } ipr_wr_t;

  // Bit s is the request of source s
  typedef logic [NUM_SRC-1:0] src_req_t;

  // Larger of two levels
  function automatic level_t max_level(input level_t a, input level_t b);
    level_t result;
    if (a > b) begin
      result = a;
    end else begin
      result = b;
    end
    return result;
  endfunction

endpackage : intc_pkg
